// File: verilog/pattern_driver_defines.svh
//######################################
// sizing of the eight-channel pattern driver
// address width must cover the memory depth
// frame layout assumes 8 data bits, one per core
//######################################

`ifndef PATTERN_DRIVER_DEFINES_SVH
`define PATTERN_DRIVER_DEFINES_SVH

// number of driver cores, each with two outputs
`define PD_NUM_DRIVERS 8

// pattern entries per core
`define PD_MEM_LENGTH 48

// bits needed to address one entry
`define PD_MEM_ADDR_W 6

// bits in one spi command frame
`define PD_FRAME_BITS 24

// flops per pin synchronizer, edge stage not included
`define PD_SYNC_STAGES 2

`endif

// File: verilog/pattern_driver_pkg.sv
//######################################
// shared types of the pattern driver
// widths follow the defines header
//######################################

`include "pattern_driver_defines.svh"

package pattern_driver_pkg;

  // command field, frame bits [23:22]
  typedef enum logic [1:0] {
    CMD_NOP    = 2'd0,
    CMD_WRITE  = 2'd1,
    CMD_INVERT = 2'd2,
    CMD_ENABLE = 2'd3
  } cmd_e;

  // address of one pattern entry
  typedef logic [`PD_MEM_ADDR_W-1:0] mem_addr_t;

  // selects one of the driver cores
  typedef logic [$clog2(`PD_NUM_DRIVERS)-1:0] driver_idx_t;

  // bit 0 drives the lower output of the pair
  typedef logic [1:0] entry_t;

endpackage

// File: verilog/pin_sync.sv
//######################################
// all pins are asynchronous to user_clock2_i
// pulses are one cycle wide, a few cycles late
// sclk needs 4 cycles per level to be seen
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module pin_sync (
  input  logic user_clock2_i,
  input  logic reset_i,
  input  logic sclk_i,
  input  logic mosi_i,
  input  logic ss_n_i,
  input  logic control_trigger_i,
  input  logic latch_data_i,
  output logic sclk_rise_o,
  output logic mosi_o,
  output logic ss_active_o,
  output logic ss_rise_o,
  output logic trigger_rise_o,
  output logic latch_rise_o
);

  localparam int SCLK_B = 0;
  localparam int MOSI_B = 1;
  localparam int SS_B   = 2;
  localparam int TRIG_B = 3;
  localparam int LATCH_B = 4;
  // ss_n idles high, everything else low
  localparam logic [4:0] PIN_IDLE = 5'b00100;

  logic [4:0] pins_in;
  logic [4:0] stage_q [`PD_SYNC_STAGES+1];
  logic [4:0] cur;
  logic [4:0] prev;
  logic [4:0] rise;

  assign pins_in = {latch_data_i, control_trigger_i, ss_n_i, mosi_i, sclk_i};

  // sync chain plus one stage kept for edge detection
  always_ff @(posedge user_clock2_i) begin
    if (reset_i) begin
      for (int i = 0; i <= `PD_SYNC_STAGES; i++) stage_q[i] <= PIN_IDLE;
    end else begin
      stage_q[0] <= pins_in;
      for (int i = 1; i <= `PD_SYNC_STAGES; i++) stage_q[i] <= stage_q[i-1];
    end
  end

  assign cur  = stage_q[`PD_SYNC_STAGES-1];
  assign prev = stage_q[`PD_SYNC_STAGES];
  assign rise = cur & ~prev;

  assign sclk_rise_o    = rise[SCLK_B];
  assign mosi_o         = cur[MOSI_B];
  assign ss_active_o    = ~cur[SS_B];
  // rising ss_n ends the transfer
  assign ss_rise_o      = rise[SS_B];
  assign trigger_rise_o = rise[TRIG_B];
  assign latch_rise_o   = rise[LATCH_B];

endmodule

// File: verilog/spi_frame_rx.sv
//######################################
// spi mode 0 slave, msb first, receive only
// a frame counts only with exactly 24 sclk rises
// while ss is low, anything else is dropped
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module spi_frame_rx (
  input  logic                      user_clock2_i,
  input  logic                      reset_i,
  input  logic                      sclk_rise_i,
  input  logic                      mosi_i,
  input  logic                      ss_active_i,
  input  logic                      ss_rise_i,
  output logic                      frame_valid_o,
  output logic [`PD_FRAME_BITS-1:0] frame_data_o
);

  // one spare count above a full frame so overlong frames stay invalid
  localparam int CNT_W = $clog2(`PD_FRAME_BITS + 2);

  logic [`PD_FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]          bit_cnt_q;
  logic                      frame_valid_q;
  logic                      full_frame;

  assign full_frame = (bit_cnt_q == CNT_W'(`PD_FRAME_BITS));

  // shift register holds the frame until the next transfer starts
  always_ff @(posedge user_clock2_i) begin
    if (sclk_rise_i && ss_active_i) begin
      shift_q <= {shift_q[`PD_FRAME_BITS-2:0], mosi_i};
    end
  end

  always_ff @(posedge user_clock2_i) begin
    if (reset_i) begin
      bit_cnt_q     <= '0;
      frame_valid_q <= 1'b0;
    end else begin
      frame_valid_q <= ss_rise_i && full_frame;
      if (ss_rise_i) begin
        bit_cnt_q <= '0;
      end else if (sclk_rise_i && ss_active_i && bit_cnt_q != '1) begin
        // saturate, never wraps back onto a valid count
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  assign frame_valid_o = frame_valid_q;
  assign frame_data_o  = shift_q;

endmodule

// File: verilog/command_decoder.sv
//######################################
// acts one cycle after frame_valid_i
// writes to addresses past the memory end are dropped
// inversion mask only goes live on a latch edge
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module command_decoder (
  input  logic                              user_clock2_i,
  input  logic                              reset_i,
  input  logic                              frame_valid_i,
  input  logic [`PD_FRAME_BITS-1:0]         frame_data_i,
  input  logic                              latch_rise_i,
  output logic [`PD_NUM_DRIVERS-1:0]        mem_we_o,
  output pattern_driver_pkg::mem_addr_t     mem_waddr_o,
  output pattern_driver_pkg::entry_t        mem_wdata_o,
  output logic [`PD_NUM_DRIVERS-1:0]        invert_mask_o,
  output logic                              output_enable_o
);

  localparam int NUM_DRV = `PD_NUM_DRIVERS;

  pattern_driver_pkg::cmd_e        cmd;
  pattern_driver_pkg::driver_idx_t idx;
  pattern_driver_pkg::mem_addr_t   addr;
  logic [NUM_DRV-1:0]              we_d;
  logic [NUM_DRV-1:0]              mem_we_q;
  logic [NUM_DRV-1:0]              staged_mask_q;
  logic [NUM_DRV-1:0]              live_mask_q;
  logic                            enable_q;
  pattern_driver_pkg::mem_addr_t   waddr_q;
  pattern_driver_pkg::entry_t      wdata_q;

  // frame fields: cmd [23:22], index [21:19], address [18:13], data [7:0]
  assign cmd  = pattern_driver_pkg::cmd_e'(frame_data_i[23:22]);
  assign idx  = frame_data_i[21:19];
  assign addr = frame_data_i[18:13];

  // one-hot write strobe toward the addressed core
  always_comb begin
    we_d = '0;
    if (frame_valid_i && cmd == pattern_driver_pkg::CMD_WRITE &&
        addr < `PD_MEM_LENGTH) begin
      for (int i = 0; i < NUM_DRV; i++) we_d[i] = (idx == i);
    end
  end

  always_ff @(posedge user_clock2_i) begin
    if (reset_i) begin
      mem_we_q      <= '0;
      staged_mask_q <= '0;
      live_mask_q   <= '0;
      enable_q      <= 1'b0;
    end else begin
      mem_we_q <= we_d;
      if (frame_valid_i) begin
        case (cmd)
          pattern_driver_pkg::CMD_INVERT: staged_mask_q <= frame_data_i[NUM_DRV-1:0];
          pattern_driver_pkg::CMD_ENABLE: enable_q      <= frame_data_i[0];
          default: ;
        endcase
      end
      // latch edge sees the mask staged before this cycle
      if (latch_rise_i) begin
        live_mask_q <= staged_mask_q;
      end
    end
  end

  // write payload, qualified by mem_we_q
  always_ff @(posedge user_clock2_i) begin
    if (frame_valid_i) begin
      waddr_q <= addr;
      wdata_q <= frame_data_i[1:0];
    end
  end

  assign mem_we_o        = mem_we_q;
  assign mem_waddr_o     = waddr_q;
  assign mem_wdata_o     = wdata_q;
  assign invert_mask_o   = live_mask_q;
  assign output_enable_o = enable_q;

endmodule

// File: verilog/update_sequencer.sv
//######################################
// triggers while busy are ignored
// completion pulse lines up with the cores
// showing the last entry on their outputs
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module update_sequencer (
  input  logic                          user_clock2_i,
  input  logic                          reset_i,
  input  logic                          trigger_rise_i,
  output logic                          rd_en_o,
  output pattern_driver_pkg::mem_addr_t rd_addr_o,
  output logic                          update_cycle_complete_o
);

  localparam pattern_driver_pkg::mem_addr_t LAST_ADDR = `PD_MEM_LENGTH - 1;

  logic                          busy_q;
  pattern_driver_pkg::mem_addr_t addr_q;
  logic                          complete_q;
  logic                          last_step;

  assign last_step = busy_q && (addr_q == LAST_ADDR);

  always_ff @(posedge user_clock2_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      addr_q     <= '0;
      complete_q <= 1'b0;
    end else begin
      // cores register the last entry on this same edge
      complete_q <= last_step;
      if (!busy_q) begin
        if (trigger_rise_i) begin
          busy_q <= 1'b1;
          addr_q <= '0;
        end
      end else if (last_step) begin
        busy_q <= 1'b0;
        addr_q <= '0;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign rd_en_o                 = busy_q;
  assign rd_addr_o               = addr_q;
  assign update_cycle_complete_o = complete_q;

endmodule

// File: verilog/driver_core.sv
//######################################
// one channel, two outputs
// output holds between sweeps
// enable low forces the pair to zero at once
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module driver_core #(
  parameter int MEM_LENGTH = `PD_MEM_LENGTH
) (
  input  logic                          user_clock2_i,
  input  logic                          reset_i,
  input  logic                          we_i,
  input  pattern_driver_pkg::mem_addr_t waddr_i,
  input  pattern_driver_pkg::entry_t    wdata_i,
  input  logic                          rd_en_i,
  input  pattern_driver_pkg::mem_addr_t rd_addr_i,
  input  logic                          invert_i,
  input  logic                          enable_i,
  output pattern_driver_pkg::entry_t    driver_io_o
);

  pattern_driver_pkg::entry_t mem [MEM_LENGTH];
  pattern_driver_pkg::entry_t out_q;

  // pattern storage, contents undefined until written
  always_ff @(posedge user_clock2_i) begin
    if (we_i && waddr_i < MEM_LENGTH) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  always_ff @(posedge user_clock2_i) begin
    if (reset_i) begin
      out_q <= '0;
    end else if (rd_en_i) begin
      // mask bit flips both outputs of the pair
      out_q <= mem[rd_addr_i] ^ {2{invert_i}};
    end
  end

  assign driver_io_o = enable_i ? out_q : '0;

endmodule

// File: verilog/pattern_driver_top.sv
//######################################
// eight-channel serial-programmed pattern driver
// single clock domain, synchronous reset
// no frames may be sent during an update
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module pattern_driver_top (
  input  logic                            user_clock2_i,
  input  logic                            reset_i,
  input  logic                            sclk_i,
  input  logic                            mosi_i,
  input  logic                            ss_n_i,
  input  logic                            control_trigger_i,
  input  logic                            latch_data_i,
  output logic [2*`PD_NUM_DRIVERS-1:0]    driver_io_o,
  output logic                            update_cycle_complete_o
);

  logic                          sclk_rise;
  logic                          mosi_s;
  logic                          ss_active;
  logic                          ss_rise;
  logic                          trigger_rise;
  logic                          latch_rise;
  logic                          frame_valid;
  logic [`PD_FRAME_BITS-1:0]     frame_data;
  logic [`PD_NUM_DRIVERS-1:0]    mem_we;
  pattern_driver_pkg::mem_addr_t mem_waddr;
  pattern_driver_pkg::entry_t    mem_wdata;
  logic [`PD_NUM_DRIVERS-1:0]    invert_mask;
  logic                          output_enable;
  logic                          rd_en;
  pattern_driver_pkg::mem_addr_t rd_addr;

  pin_sync pin_sync_i (
    .user_clock2_i     (user_clock2_i),
    .reset_i           (reset_i),
    .sclk_i            (sclk_i),
    .mosi_i            (mosi_i),
    .ss_n_i            (ss_n_i),
    .control_trigger_i (control_trigger_i),
    .latch_data_i      (latch_data_i),
    .sclk_rise_o       (sclk_rise),
    .mosi_o            (mosi_s),
    .ss_active_o       (ss_active),
    .ss_rise_o         (ss_rise),
    .trigger_rise_o    (trigger_rise),
    .latch_rise_o      (latch_rise)
  );

  spi_frame_rx spi_frame_rx_i (
    .user_clock2_i (user_clock2_i),
    .reset_i       (reset_i),
    .sclk_rise_i   (sclk_rise),
    .mosi_i        (mosi_s),
    .ss_active_i   (ss_active),
    .ss_rise_i     (ss_rise),
    .frame_valid_o (frame_valid),
    .frame_data_o  (frame_data)
  );

  command_decoder command_decoder_i (
    .user_clock2_i   (user_clock2_i),
    .reset_i         (reset_i),
    .frame_valid_i   (frame_valid),
    .frame_data_i    (frame_data),
    .latch_rise_i    (latch_rise),
    .mem_we_o        (mem_we),
    .mem_waddr_o     (mem_waddr),
    .mem_wdata_o     (mem_wdata),
    .invert_mask_o   (invert_mask),
    .output_enable_o (output_enable)
  );

  update_sequencer update_sequencer_i (
    .user_clock2_i           (user_clock2_i),
    .reset_i                 (reset_i),
    .trigger_rise_i          (trigger_rise),
    .rd_en_o                 (rd_en),
    .rd_addr_o               (rd_addr),
    .update_cycle_complete_o (update_cycle_complete_o)
  );

  // all cores share the write bus and the read sweep
  for (genvar n = 0; n < `PD_NUM_DRIVERS; n++) begin : gen_core
    driver_core #(
      .MEM_LENGTH (`PD_MEM_LENGTH)
    ) core_i (
      .user_clock2_i (user_clock2_i),
      .reset_i       (reset_i),
      .we_i          (mem_we[n]),
      .waddr_i       (mem_waddr),
      .wdata_i       (mem_wdata),
      .rd_en_i       (rd_en),
      .rd_addr_i     (rd_addr),
      .invert_i      (invert_mask[n]),
      .enable_i      (output_enable),
      .driver_io_o   (driver_io_o[2*n +: 2])
    );
  end

endmodule

// File: test/pattern_driver_chk.sv
//######################################
// protocol checks bound into pattern_driver_top
// watches the internal enable and read sweep
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module pattern_driver_chk (
  input logic                         clk_i,
  input logic                         reset_i,
  input logic                         complete_i,
  input logic [2*`PD_NUM_DRIVERS-1:0] driver_io_i,
  input logic                         output_enable_i,
  input logic                         rd_en_i,
  input logic [`PD_MEM_ADDR_W-1:0]    rd_addr_i,
  input logic                         trigger_rise_i
);

  localparam logic [`PD_MEM_ADDR_W-1:0] LAST_ADDR = `PD_MEM_LENGTH - 1;

  // number of assertion failures so far
  int fail_count = 0;

  // completion is a single-cycle pulse
  single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    complete_i |=> !complete_i)
    else begin
      $error("update_cycle_complete_o high for two cycles in a row");
      fail_count++;
    end

  enable_gate: assert property (@(posedge clk_i) disable iff (reset_i)
    !output_enable_i |-> driver_io_i == '0)
    else begin
      $error("driver_io_o not zero while outputs are disabled");
      fail_count++;
    end

  // a trigger mid-sweep must not pull the address back
  no_restart: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_en_i && trigger_rise_i && rd_addr_i != LAST_ADDR
    |=> rd_en_i && rd_addr_i == $past(rd_addr_i) + 1'b1)
    else begin
      $error("trigger during an update disturbed the address sweep");
      fail_count++;
    end

endmodule

bind pattern_driver_top pattern_driver_chk chk_i (
  .clk_i           (user_clock2_i),
  .reset_i         (reset_i),
  .complete_i      (update_cycle_complete_o),
  .driver_io_i     (driver_io_o),
  .output_enable_i (output_enable),
  .rd_en_i         (rd_en),
  .rd_addr_i       (rd_addr),
  .trigger_rise_i  (trigger_rise)
);

// File: test/pattern_driver_tb.sv
//######################################
// random pattern fill from a fixed seed
// no frames are sent while an update runs
// frames are spaced by fixed idle gaps
//######################################

`timescale 1ns/1ps
`include "pattern_driver_defines.svh"

module pattern_driver_tb;

  localparam int NUM_DRV   = `PD_NUM_DRIVERS;
  localparam int MEM_LEN   = `PD_MEM_LENGTH;
  localparam int HALF_SCLK = 4;
  localparam int UPD_LIMIT = 200;

  logic clk;
  logic reset;
  logic sclk;
  logic mosi;
  logic ss_n;
  logic trigger;
  logic latch;
  logic [2*NUM_DRV-1:0] driver_io;
  logic update_done;

  // reference model
  logic [1:0]         model_mem [NUM_DRV][MEM_LEN];
  logic [NUM_DRV-1:0] model_staged;
  logic [NUM_DRV-1:0] model_live;
  logic               model_enable;

  logic [2*NUM_DRV-1:0] samples [$];
  int pulse_count;
  int pulse_cycle;
  int checks;
  int errors;
  integer seed;

  pattern_driver_top dut_i (
    .user_clock2_i           (clk),
    .reset_i                 (reset),
    .sclk_i                  (sclk),
    .mosi_i                  (mosi),
    .ss_n_i                  (ss_n),
    .control_trigger_i       (trigger),
    .latch_data_i            (latch),
    .driver_io_o             (driver_io),
    .update_cycle_complete_o (update_done)
  );

  always #5 clk = ~clk;

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  function automatic logic [23:0] make_frame(input logic [1:0] cmd, input int idx,
                                             input int addr, input logic [7:0] data);
    make_frame = {cmd, 3'(idx), 6'(addr), 5'b0, data};
  endfunction

  // bit-banged spi mode 0, msb first, sends the lowest nbits of the frame
  task automatic send_frame(input logic [23:0] frame, input int nbits);
    @(posedge clk);
    ss_n <= 1'b0;
    idle_cycles(HALF_SCLK);
    for (int i = 0; i < nbits; i++) begin
      mosi <= frame[nbits-1-i];
      idle_cycles(HALF_SCLK);
      sclk <= 1'b1;
      idle_cycles(HALF_SCLK);
      sclk <= 1'b0;
    end
    idle_cycles(HALF_SCLK);
    ss_n <= 1'b1;
    // room for sync, frame check, decode and the memory write
    idle_cycles(10);
  endtask

  task automatic write_entry(input int idx, input int addr, input logic [1:0] value);
    send_frame(make_frame(pattern_driver_pkg::CMD_WRITE, idx, addr, {6'b0, value}), 24);
    if (addr < MEM_LEN) model_mem[idx][addr] = value;
  endtask

  task automatic set_enable(input logic on);
    send_frame(make_frame(pattern_driver_pkg::CMD_ENABLE, 0, 0, {7'b0, on}), 24);
    model_enable = on;
  endtask

  task automatic pulse_latch();
    @(posedge clk);
    latch <= 1'b1;
    idle_cycles(4);
    latch <= 1'b0;
    idle_cycles(6);
    model_live = model_staged;
  endtask

  function automatic logic [2*NUM_DRV-1:0] expected_word(input int k);
    for (int n = 0; n < NUM_DRV; n++) begin
      expected_word[2*n +: 2] = model_enable ? model_mem[n][k] ^ {2{model_live[n]}} : 2'b00;
    end
  endfunction

  // pulses the trigger, samples outputs on the falling edge until the
  // completion pulse, and with retrigger keeps watching for a stray sweep
  task automatic run_update(input bit retrigger);
    int cyc;
    int tail;
    samples.delete();
    pulse_count = 0;
    pulse_cycle = -1;
    cyc = 0;
    tail = 0;
    while (cyc < UPD_LIMIT && (pulse_count == 0 || (retrigger && tail < 70))) begin
      @(posedge clk);
      trigger <= (cyc < 4) || (retrigger && cyc >= 20 && cyc < 24);
      @(negedge clk);
      if (pulse_count == 0) samples.push_back(driver_io);
      if (update_done) begin
        pulse_count++;
        if (pulse_cycle < 0) pulse_cycle = cyc;
      end
      if (pulse_count > 0) tail++;
      cyc++;
    end
    if (pulse_count == 0) begin
      errors++;
      $display("timeout: no update_cycle_complete_o pulse within %0d cycles", UPD_LIMIT);
    end
  endtask

  // entry k sits 47-k samples before the completion sample
  task automatic check_playback(input string label);
    int base;
    if (samples.size() < MEM_LEN) begin
      errors++;
      $display("%s: only %0d output samples were captured", label, samples.size());
      return;
    end
    base = samples.size() - MEM_LEN;
    for (int k = 0; k < MEM_LEN; k++) begin
      check_value(samples[base+k], expected_word(k), $sformatf("%s entry %0d", label, k));
    end
  endtask

  initial begin
    logic [31:0] r;
    int idx;
    int addr;
    clk = 1'b0;
    reset = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    ss_n = 1'b1;
    trigger = 1'b0;
    latch = 1'b0;
    seed = 32'h38f23b11;
    checks = 0;
    errors = 0;
    model_staged = '0;
    model_live = '0;
    model_enable = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value(driver_io, 0, "driver_io_o after reset");
    check_value(update_done, 0, "update_cycle_complete_o after reset");

    for (int n = 0; n < NUM_DRV; n++) begin
      for (int a = 0; a < MEM_LEN; a++) begin
        r = $random(seed);
        write_entry(n, a, r[1:0]);
      end
    end
    set_enable(1'b1);
    run_update(1'b0);
    check_playback("playback");

    // mask is staged only, outputs must not invert yet
    r = $random(seed);
    send_frame(make_frame(pattern_driver_pkg::CMD_INVERT, 0, 0, r[7:0]), 24);
    model_staged = r[7:0];
    run_update(1'b0);
    check_playback("staged mask");
    pulse_latch();
    run_update(1'b0);
    check_playback("latched mask");

    set_enable(1'b0);
    run_update(1'b0);
    foreach (samples[i]) check_value(samples[i], 0, "output while disabled");
    check_value(pulse_count, 1, "completion pulses while disabled");

    // short frame and out-of-range write must leave memory alone
    // the disable frame ends in a zero, so a short frame taken as
    // complete would land as a full write
    r = $random(seed);
    idx = r[2:0];
    addr = r[8:3] % MEM_LEN;
    send_frame(make_frame(pattern_driver_pkg::CMD_WRITE, idx, addr,
                          {6'b0, ~model_mem[idx][addr]}), 23);
    r = $random(seed);
    write_entry(r[2:0], 50, r[4:3]);
    set_enable(1'b1);
    run_update(1'b0);
    check_playback("after rejected frames");

    run_update(1'b1);
    check_value(pulse_count, 1, "completion pulses with a second trigger");
    if (pulse_cycle < 45 || pulse_cycle > 60) begin
      errors++;
      $display("completion pulse came %0d cycles after the trigger, outside 45 to 60",
               pulse_cycle);
    end
    check_playback("second trigger");

    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             dut_i.chk_i.fail_count);
    if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/pattern_driver_pkg.sv
verilog/pin_sync.sv
verilog/spi_frame_rx.sv
verilog/command_decoder.sv
verilog/update_sequencer.sv
verilog/driver_core.sv
verilog/pattern_driver_top.sv
test/pattern_driver_chk.sv
test/pattern_driver_tb.sv
